//--- rtl/capture_pkg.sv
package capture_pkg;

  typedef logic [31:0] data_t;      // Bus and memory word
  typedef logic [3:0]  strb_t;      // One strobe per byte
  typedef logic [1:0]  resp_t;      // AXI response code
  typedef logic [11:0] reg_addr_t;  // AXI4-Lite byte address

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // Register map
  localparam reg_addr_t REG_CTRL        = 12'h000;  // Enable and clear
  localparam reg_addr_t REG_STATUS      = 12'h004;  // Count and flags
  localparam reg_addr_t REG_ID          = 12'h008;  // Fixed ID word
  localparam reg_addr_t MEM_WINDOW_BASE = 12'h800;  // Upper half maps the RAM

  localparam int WINDOW_SEL_BIT = 11;  // Set for 0x800 to 0xFFF

  localparam data_t CAPTURE_ID = 32'h4341_5031;  // "CAP1"

  // AXI4-Lite slave sequencing
  typedef enum logic [2:0] {
    IDLE,      // Waiting for a write or a read
    ACCESS,    // Ready pulse and local request
    WAIT_MEM,  // Waiting for reg_done
    RESP_B,    // Write response held
    RESP_R     // Read data held
  } lite_state_e;

endpackage

//--- rtl/shared_ram.sv
`timescale 1ns/1ps

module shared_ram #(
  parameter int MEM_ADDR_WIDTH = 6
) (
  input  logic                      aclk,
  input  logic                      ram_we,
  input  logic [MEM_ADDR_WIDTH-1:0] ram_addr,
  input  logic [31:0]               ram_wdata,
  input  logic [3:0]                ram_wstrb,
  output logic [31:0]               ram_rdata
);

  localparam int DEPTH = 2 ** MEM_ADDR_WIDTH;

  logic [31:0] mem [DEPTH];  // No reset on contents

  always_ff @(posedge aclk) begin
    for (int b = 0; b < 4; b++) begin
      if (ram_we && ram_wstrb[b]) begin
        mem[ram_addr][8*b +: 8] <= ram_wdata[8*b +: 8];  // Byte lane merge
      end
    end
    ram_rdata <= mem[ram_addr];  // Old data on a same-cycle write
  end

endmodule

//--- rtl/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter #(
  parameter int MEM_ADDR_WIDTH = 6
) (
  input  logic                      aclk,
  input  logic                      reset,
  // Client 0, register window
  input  logic                      c0_req,
  input  logic                      c0_we,
  input  logic [MEM_ADDR_WIDTH-1:0] c0_addr,
  input  capture_pkg::data_t        c0_wdata,
  input  capture_pkg::strb_t        c0_wstrb,
  output logic                      c0_gnt,
  // Client 1, stream writes
  input  logic                      c1_req,
  input  logic [MEM_ADDR_WIDTH-1:0] c1_addr,
  input  capture_pkg::data_t        c1_wdata,
  output logic                      c1_gnt,
  // Shared read data, one cycle after grant
  output capture_pkg::data_t        rdata,
  // RAM port
  output logic                      ram_we,
  output logic [MEM_ADDR_WIDTH-1:0] ram_addr,
  output capture_pkg::data_t        ram_wdata,
  output capture_pkg::strb_t        ram_wstrb,
  input  capture_pkg::data_t        ram_rdata
);
  import capture_pkg::*;

  localparam strb_t FULL_STRB = '1;  // Stream stores whole words

  logic last_c1;  // Client 1 won the last grant

  // Loser of the last round goes first on a tie
  assign c0_gnt = c0_req && (!c1_req || last_c1);
  assign c1_gnt = c1_req && !c0_gnt;

  assign ram_we    = c0_gnt ? c0_we : c1_gnt;  // Client 1 only writes
  assign ram_addr  = c1_gnt ? c1_addr : c0_addr;
  assign ram_wdata = c1_gnt ? c1_wdata : c0_wdata;
  assign ram_wstrb = c1_gnt ? FULL_STRB : c0_wstrb;
  assign rdata     = ram_rdata;

  always_ff @(posedge aclk) begin
    if (reset) begin
      last_c1 <= 1'b0;
    end else if (c0_gnt) begin
      last_c1 <= 1'b0;
    end else if (c1_gnt) begin
      last_c1 <= 1'b1;
    end
  end

endmodule

//--- rtl/stream_sink.sv
`timescale 1ns/1ps

module stream_sink #(
  parameter int MEM_ADDR_WIDTH = 6
) (
  input  logic                      aclk,
  input  logic                      reset,
  // AXI4-Stream slave
  input  capture_pkg::data_t        s_axi_stream_tdata,
  input  logic                      s_axi_stream_tvalid,
  output logic                      s_axi_stream_tready,
  input  logic                      s_axi_stream_tlast,
  // Control from the register file
  input  logic                      capture_en,
  input  logic                      clear,
  // Memory client 1, write only
  output logic                      mem_req,
  output logic [MEM_ADDR_WIDTH-1:0] mem_addr,
  output capture_pkg::data_t        mem_wdata,
  input  logic                      mem_gnt,
  // Status
  output logic [MEM_ADDR_WIDTH:0]   word_count,
  output logic                      buf_full,
  output logic                      frame_done
);

  logic beat;  // Word accepted this cycle

  assign buf_full = word_count[MEM_ADDR_WIDTH];  // Count reached the depth
  assign mem_req  = capture_en && s_axi_stream_tvalid && !buf_full;

  // Ready only while the RAM port is ours
  assign s_axi_stream_tready = mem_gnt;
  assign beat                = s_axi_stream_tvalid && s_axi_stream_tready;

  assign mem_addr  = word_count[MEM_ADDR_WIDTH-1:0];  // Next free word
  assign mem_wdata = s_axi_stream_tdata;

  always_ff @(posedge aclk) begin
    if (reset || clear) begin  // Clear wins over a beat
      word_count <= '0;
      frame_done <= 1'b0;
    end else if (beat) begin
      word_count <= word_count + 1'b1;
      if (s_axi_stream_tlast) begin
        frame_done <= 1'b1;  // Sticky until clear
      end
    end
  end

endmodule

//--- rtl/ctrl_regs.sv
`timescale 1ns/1ps

module ctrl_regs #(
  parameter int MEM_ADDR_WIDTH = 6
) (
  input  logic                      aclk,
  input  logic                      reset,
  // Local register bus
  input  logic                      reg_req,
  input  logic                      reg_write,
  input  capture_pkg::reg_addr_t    reg_addr,
  input  capture_pkg::data_t        reg_wdata,
  input  capture_pkg::strb_t        reg_wstrb,
  output logic                      reg_done,
  output capture_pkg::data_t        reg_rdata,
  output logic                      reg_err,
  // Memory client 0
  output logic                      mem_req,
  output logic                      mem_we,
  output logic [MEM_ADDR_WIDTH-1:0] mem_addr,
  output capture_pkg::data_t        mem_wdata,
  output capture_pkg::strb_t        mem_wstrb,
  input  logic                      mem_gnt,
  input  capture_pkg::data_t        mem_rdata,
  // Capture control and status
  input  logic [MEM_ADDR_WIDTH:0]   word_count,
  input  logic                      buf_full,
  input  logic                      frame_done,
  output logic                      capture_en,
  output logic                      clear
);
  import capture_pkg::*;

  logic      win_sel;     // Access goes to the RAM
  reg_addr_t win_off;     // Byte offset inside the window
  logic      reg_hit;     // Address is a defined register
  data_t     reg_value;   // Read mux result
  data_t     rdata_q;
  logic      win_done_q;  // Window access granted last cycle

  assign win_sel = reg_addr[WINDOW_SEL_BIT];
  assign win_off = reg_addr - MEM_WINDOW_BASE;

  // Slave keeps the bus fields stable until reg_done
  assign mem_we    = reg_write;
  assign mem_addr  = win_off[2 +: MEM_ADDR_WIDTH];  // Word index
  assign mem_wdata = reg_wdata;
  assign mem_wstrb = reg_wstrb;

  // RAM data arrives one cycle after the grant
  assign reg_rdata = win_done_q ? mem_rdata : rdata_q;

  always_comb begin
    reg_hit = 1'b1;
    case (reg_addr)
      REG_CTRL:   reg_value = {30'd0, 1'b0, capture_en};  // Clear bit reads 0
      REG_STATUS: reg_value = {buf_full, frame_done, 14'd0, 16'(word_count)};
      REG_ID:     reg_value = CAPTURE_ID;
      default: begin
        reg_value = '0;  // Unmapped reads 0
        reg_hit   = 1'b0;
      end
    endcase
  end

  always_ff @(posedge aclk) begin
    if (reset) begin
      reg_done   <= 1'b0;
      reg_err    <= 1'b0;
      mem_req    <= 1'b0;
      win_done_q <= 1'b0;
      capture_en <= 1'b0;
      clear      <= 1'b0;
    end else begin
      reg_done   <= (reg_req && !win_sel) || (mem_req && mem_gnt);
      win_done_q <= mem_req && mem_gnt;
      clear      <= 1'b0;  // Pulse only
      if (reg_req && win_sel) begin
        mem_req <= 1'b1;  // Hold until granted
      end else if (mem_gnt) begin
        mem_req <= 1'b0;
      end
      if (reg_req && !win_sel) begin
        reg_err <= !reg_hit;
        if (reg_write && reg_addr == REG_CTRL && reg_wstrb[0]) begin
          capture_en <= reg_wdata[0];
          clear      <= reg_wdata[1];
        end
      end else if (mem_req && mem_gnt) begin
        reg_err <= 1'b0;  // Window always OKAY
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (reg_req) begin
      rdata_q <= reg_value;
    end
  end

endmodule

//--- rtl/axi_lite_slave.sv
`timescale 1ns/1ps

module axi_lite_slave (
  input  logic                   aclk,
  input  logic                   reset,
  // Write address and data
  input  capture_pkg::reg_addr_t s_axi_lite_awaddr,
  input  logic                   s_axi_lite_awvalid,
  output logic                   s_axi_lite_awready,
  input  capture_pkg::data_t     s_axi_lite_wdata,
  input  capture_pkg::strb_t     s_axi_lite_wstrb,
  input  logic                   s_axi_lite_wvalid,
  output logic                   s_axi_lite_wready,
  // Write response
  output capture_pkg::resp_t     s_axi_lite_bresp,
  output logic                   s_axi_lite_bvalid,
  input  logic                   s_axi_lite_bready,
  // Read address and data
  input  capture_pkg::reg_addr_t s_axi_lite_araddr,
  input  logic                   s_axi_lite_arvalid,
  output logic                   s_axi_lite_arready,
  output capture_pkg::data_t     s_axi_lite_rdata,
  output capture_pkg::resp_t     s_axi_lite_rresp,
  output logic                   s_axi_lite_rvalid,
  input  logic                   s_axi_lite_rready,
  // Local register bus
  output logic                   reg_req,
  output logic                   reg_write,
  output capture_pkg::reg_addr_t reg_addr,
  output capture_pkg::data_t     reg_wdata,
  output capture_pkg::strb_t     reg_wstrb,
  input  logic                   reg_done,
  input  capture_pkg::data_t     reg_rdata,
  input  logic                   reg_err
);
  import capture_pkg::*;

  lite_state_e state;
  logic        wr_start;  // Both write channels present
  data_t       rdata_q;   // Captured read data
  resp_t       resp_q;    // Captured response

  assign wr_start = s_axi_lite_awvalid && s_axi_lite_wvalid;

  // Ready pulses come out of the ACCESS state, one cycle long
  assign s_axi_lite_awready = (state == ACCESS) && reg_write;
  assign s_axi_lite_wready  = (state == ACCESS) && reg_write;
  assign s_axi_lite_arready = (state == ACCESS) && !reg_write;
  assign reg_req            = (state == ACCESS);  // Single pulse per transaction

  assign s_axi_lite_bvalid = (state == RESP_B);
  assign s_axi_lite_bresp  = resp_q;
  assign s_axi_lite_rvalid = (state == RESP_R);
  assign s_axi_lite_rdata  = rdata_q;
  assign s_axi_lite_rresp  = resp_q;

  always_ff @(posedge aclk) begin
    if (reset) begin
      state     <= IDLE;
      reg_write <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (wr_start) begin  // Write wins over read
            reg_write <= 1'b1;
            state     <= ACCESS;
          end else if (s_axi_lite_arvalid) begin
            reg_write <= 1'b0;
            state     <= ACCESS;
          end
        end
        ACCESS: state <= WAIT_MEM;  // Handshake done here
        WAIT_MEM: begin
          if (reg_done) begin
            state <= reg_write ? RESP_B : RESP_R;
          end
        end
        RESP_B: begin
          if (s_axi_lite_bready) begin
            state <= IDLE;
          end
        end
        RESP_R: begin
          if (s_axi_lite_rready) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Payload, no reset
  always_ff @(posedge aclk) begin
    if (state == IDLE) begin  // Valid payload is stable until ready
      reg_addr  <= wr_start ? s_axi_lite_awaddr : s_axi_lite_araddr;
      reg_wdata <= s_axi_lite_wdata;
      reg_wstrb <= s_axi_lite_wstrb;
    end
    if (state == WAIT_MEM && reg_done) begin
      rdata_q <= reg_rdata;
      resp_q  <= reg_err ? RESP_SLVERR : RESP_OKAY;
    end
  end

endmodule

//--- rtl/axi_capture_top.sv
`timescale 1ns/1ps

module axi_capture_top #(
  parameter int MEM_ADDR_WIDTH = 6  // At most 9 to fit the window
) (
  input  logic                   aclk,
  input  logic                   reset,
  // AXI4-Lite slave
  input  capture_pkg::reg_addr_t s_axi_lite_awaddr,
  input  logic                   s_axi_lite_awvalid,
  output logic                   s_axi_lite_awready,
  input  capture_pkg::data_t     s_axi_lite_wdata,
  input  capture_pkg::strb_t     s_axi_lite_wstrb,
  input  logic                   s_axi_lite_wvalid,
  output logic                   s_axi_lite_wready,
  output capture_pkg::resp_t     s_axi_lite_bresp,
  output logic                   s_axi_lite_bvalid,
  input  logic                   s_axi_lite_bready,
  input  capture_pkg::reg_addr_t s_axi_lite_araddr,
  input  logic                   s_axi_lite_arvalid,
  output logic                   s_axi_lite_arready,
  output capture_pkg::data_t     s_axi_lite_rdata,
  output capture_pkg::resp_t     s_axi_lite_rresp,
  output logic                   s_axi_lite_rvalid,
  input  logic                   s_axi_lite_rready,
  // AXI4-Stream slave
  input  capture_pkg::data_t     s_axi_stream_tdata,
  input  logic                   s_axi_stream_tvalid,
  output logic                   s_axi_stream_tready,
  input  logic                   s_axi_stream_tlast
);
  import capture_pkg::*;

  // Local register bus
  logic      reg_req;
  logic      reg_write;
  reg_addr_t reg_addr;
  data_t     reg_wdata;
  strb_t     reg_wstrb;
  logic      reg_done;
  data_t     reg_rdata;
  logic      reg_err;

  // Memory clients
  logic                      c0_req;
  logic                      c0_we;
  logic [MEM_ADDR_WIDTH-1:0] c0_addr;
  data_t                     c0_wdata;
  strb_t                     c0_wstrb;
  logic                      c0_gnt;
  logic                      c1_req;
  logic [MEM_ADDR_WIDTH-1:0] c1_addr;
  data_t                     c1_wdata;
  logic                      c1_gnt;
  data_t                     mem_rdata;  // Shared by both clients

  // RAM port
  logic                      ram_we;
  logic [MEM_ADDR_WIDTH-1:0] ram_addr;
  data_t                     ram_wdata;
  strb_t                     ram_wstrb;
  data_t                     ram_rdata;

  // Capture control and status
  logic                    capture_en;
  logic                    clear;
  logic [MEM_ADDR_WIDTH:0] word_count;
  logic                    buf_full;
  logic                    frame_done;

  axi_lite_slave axi_lite_slave_inst (
    .aclk               (aclk),
    .reset              (reset),
    .s_axi_lite_awaddr  (s_axi_lite_awaddr),
    .s_axi_lite_awvalid (s_axi_lite_awvalid),
    .s_axi_lite_awready (s_axi_lite_awready),
    .s_axi_lite_wdata   (s_axi_lite_wdata),
    .s_axi_lite_wstrb   (s_axi_lite_wstrb),
    .s_axi_lite_wvalid  (s_axi_lite_wvalid),
    .s_axi_lite_wready  (s_axi_lite_wready),
    .s_axi_lite_bresp   (s_axi_lite_bresp),
    .s_axi_lite_bvalid  (s_axi_lite_bvalid),
    .s_axi_lite_bready  (s_axi_lite_bready),
    .s_axi_lite_araddr  (s_axi_lite_araddr),
    .s_axi_lite_arvalid (s_axi_lite_arvalid),
    .s_axi_lite_arready (s_axi_lite_arready),
    .s_axi_lite_rdata   (s_axi_lite_rdata),
    .s_axi_lite_rresp   (s_axi_lite_rresp),
    .s_axi_lite_rvalid  (s_axi_lite_rvalid),
    .s_axi_lite_rready  (s_axi_lite_rready),
    .reg_req            (reg_req),
    .reg_write          (reg_write),
    .reg_addr           (reg_addr),
    .reg_wdata          (reg_wdata),
    .reg_wstrb          (reg_wstrb),
    .reg_done           (reg_done),
    .reg_rdata          (reg_rdata),
    .reg_err            (reg_err)
  );

  ctrl_regs #(.MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)) ctrl_regs_inst (
    .aclk       (aclk),
    .reset      (reset),
    .reg_req    (reg_req),
    .reg_write  (reg_write),
    .reg_addr   (reg_addr),
    .reg_wdata  (reg_wdata),
    .reg_wstrb  (reg_wstrb),
    .reg_done   (reg_done),
    .reg_rdata  (reg_rdata),
    .reg_err    (reg_err),
    .mem_req    (c0_req),
    .mem_we     (c0_we),
    .mem_addr   (c0_addr),
    .mem_wdata  (c0_wdata),
    .mem_wstrb  (c0_wstrb),
    .mem_gnt    (c0_gnt),
    .mem_rdata  (mem_rdata),
    .word_count (word_count),
    .buf_full   (buf_full),
    .frame_done (frame_done),
    .capture_en (capture_en),
    .clear      (clear)
  );

  stream_sink #(.MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)) stream_sink_inst (
    .aclk                (aclk),
    .reset               (reset),
    .s_axi_stream_tdata  (s_axi_stream_tdata),
    .s_axi_stream_tvalid (s_axi_stream_tvalid),
    .s_axi_stream_tready (s_axi_stream_tready),
    .s_axi_stream_tlast  (s_axi_stream_tlast),
    .capture_en          (capture_en),
    .clear               (clear),
    .mem_req             (c1_req),
    .mem_addr            (c1_addr),
    .mem_wdata           (c1_wdata),
    .mem_gnt             (c1_gnt),
    .word_count          (word_count),
    .buf_full            (buf_full),
    .frame_done          (frame_done)
  );

  mem_arbiter #(.MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)) mem_arbiter_inst (
    .aclk      (aclk),
    .reset     (reset),
    .c0_req    (c0_req),
    .c0_we     (c0_we),
    .c0_addr   (c0_addr),
    .c0_wdata  (c0_wdata),
    .c0_wstrb  (c0_wstrb),
    .c0_gnt    (c0_gnt),
    .c1_req    (c1_req),
    .c1_addr   (c1_addr),
    .c1_wdata  (c1_wdata),
    .c1_gnt    (c1_gnt),
    .rdata     (mem_rdata),
    .ram_we    (ram_we),
    .ram_addr  (ram_addr),
    .ram_wdata (ram_wdata),
    .ram_wstrb (ram_wstrb),
    .ram_rdata (ram_rdata)
  );

  shared_ram #(.MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)) shared_ram_inst (
    .aclk      (aclk),
    .ram_we    (ram_we),
    .ram_addr  (ram_addr),
    .ram_wdata (ram_wdata),
    .ram_wstrb (ram_wstrb),
    .ram_rdata (ram_rdata)
  );

endmodule

//--- verification/capture_tasks.svh
// Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
function automatic logic [31:0] take_bits(input int n);
  logic [31:0] r;
  logic        fb;
  r = '0;
  for (int i = 0; i < n; i++) begin
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    r    = {r[30:0], fb};  // Newest bit lands in the LSB
  end
  return r;
endfunction

task automatic check_value(input data_t got, input data_t exp, input string msg);
  checks++;
  if (got !== exp) begin  // Catches X as a mismatch too
    errors++;
    $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, msg, got, exp);
  end
endtask

function automatic reg_addr_t window_addr(input int idx);
  return MEM_WINDOW_BASE + reg_addr_t'(idx * 4);  // Word index to byte address
endfunction

// Byte lanes with a strobe take the new data
function automatic void model_write(input int idx, input data_t d, input strb_t s);
  for (int b = 0; b < 4; b++) begin
    if (s[b]) begin
      model_mem[idx][8*b +: 8] = d[8*b +: 8];
    end
  end
endfunction

task automatic lite_write(input reg_addr_t addr, input data_t d, input strb_t s,
                          output resp_t resp);
  int hs_cycle;
  bit seen;
  @(posedge aclk);
  #1;
  s_axi_lite_awaddr  = addr;
  s_axi_lite_awvalid = 1'b1;
  s_axi_lite_wdata   = d;
  s_axi_lite_wstrb   = s;
  s_axi_lite_wvalid  = 1'b1;
  @(negedge aclk);
  while (!s_axi_lite_awready) @(negedge aclk);
  hs_cycle = cycle;  // Handshake cycle
  check_value(s_axi_lite_wready, 1'b1, "wready together with awready");
  @(posedge aclk);
  #1;
  s_axi_lite_awvalid = 1'b0;
  s_axi_lite_wvalid  = 1'b0;
  seen = 1'b0;
  forever begin
    s_axi_lite_bready = (take_bits(2) != 0);  // Random stalls
    @(negedge aclk);
    if (s_axi_lite_bvalid && !seen) begin
      seen = 1'b1;
      if (!addr[WINDOW_SEL_BIT]) begin  // Registers answer in fixed time
        check_value(cycle - hs_cycle, 2, $sformatf("bvalid latency at %h", addr));
      end
    end
    if (s_axi_lite_bvalid && s_axi_lite_bready) break;
    @(posedge aclk);
    #1;
  end
  resp = s_axi_lite_bresp;
  @(posedge aclk);
  #1;
  s_axi_lite_bready = 1'b0;
endtask

task automatic lite_read(input reg_addr_t addr, output data_t d, output resp_t resp);
  int ar_cycle;
  bit seen;
  @(posedge aclk);
  #1;
  s_axi_lite_araddr  = addr;
  s_axi_lite_arvalid = 1'b1;
  @(negedge aclk);
  while (!s_axi_lite_arready) @(negedge aclk);
  ar_cycle = cycle;
  @(posedge aclk);
  #1;
  s_axi_lite_arvalid = 1'b0;
  seen = 1'b0;
  forever begin
    s_axi_lite_rready = (take_bits(2) != 0);
    @(negedge aclk);
    if (s_axi_lite_rvalid && !seen) begin
      seen = 1'b1;
      if (!addr[WINDOW_SEL_BIT]) begin
        check_value(cycle - ar_cycle, 2, $sformatf("rvalid latency at %h", addr));
      end
    end
    if (s_axi_lite_rvalid && s_axi_lite_rready) break;
    @(posedge aclk);
    #1;
  end
  d    = s_axi_lite_rdata;
  resp = s_axi_lite_rresp;
  @(posedge aclk);
  #1;
  s_axi_lite_rready = 1'b0;
endtask

task automatic write_check(input reg_addr_t addr, input data_t d, input strb_t s);
  resp_t r;
  lite_write(addr, d, s, r);
  check_value(r, OKAY_CODE, $sformatf("write response at %h", addr));
  if (addr[WINDOW_SEL_BIT]) begin
    model_write(int'(addr[10:2]) % DEPTH, d, s);
  end
endtask

task automatic read_check(input reg_addr_t addr, input data_t exp, input string msg);
  data_t d;
  resp_t r;
  lite_read(addr, d, r);
  check_value(r, OKAY_CODE, {msg, " response"});
  check_value(d, exp, msg);
endtask

// One stream beat after a random gap, accepted or left waiting
task automatic send_beat(input data_t d, input logic last, input bit expect_accept);
  bit accepted;
  int waited;
  int limit;
  limit = expect_accept ? 64 : 16;  // Short wait when back-pressure is expected
  @(posedge aclk);
  #1;
  repeat (take_bits(2)) begin  // tvalid gap
    @(posedge aclk);
    #1;
  end
  s_axi_stream_tdata  = d;
  s_axi_stream_tlast  = last;
  s_axi_stream_tvalid = 1'b1;
  accepted = 1'b0;
  waited   = 0;
  while (!accepted && waited < limit) begin
    @(negedge aclk);
    if (s_axi_stream_tready) begin
      accepted = 1'b1;  // Transfer on the next rising edge
    end else begin
      waited++;
    end
  end
  check_value(accepted, expect_accept, $sformatf("beat %0d accepted", model_count));
  if (accepted && model_count < DEPTH) begin
    model_mem[model_count] = d;
    model_count++;
  end
  @(posedge aclk);
  #1;
  s_axi_stream_tvalid = 1'b0;
  s_axi_stream_tlast  = 1'b0;
endtask

//--- verification/capture_tb.sv
`timescale 1ns/1ps

module capture_tb;
  import capture_pkg::*;

  localparam int MEM_ADDR_WIDTH = 6;
  localparam int DEPTH          = 2 ** MEM_ADDR_WIDTH;
  localparam int MAX_TXNS       = 400;            // Bus transactions plus beats, all tests
  localparam int TIMEOUT_CYCLES = MAX_TXNS * 50;  // Each takes well under 50 cycles

  localparam data_t ID_WORD     = 32'h4341_5031;  // Expected ID register value
  localparam resp_t OKAY_CODE   = 2'b00;          // AXI OKAY
  localparam resp_t SLVERR_CODE = 2'b10;          // AXI SLVERR

  logic      aclk;
  logic      reset;
  reg_addr_t s_axi_lite_awaddr;
  logic      s_axi_lite_awvalid;
  logic      s_axi_lite_awready;
  data_t     s_axi_lite_wdata;
  strb_t     s_axi_lite_wstrb;
  logic      s_axi_lite_wvalid;
  logic      s_axi_lite_wready;
  resp_t     s_axi_lite_bresp;
  logic      s_axi_lite_bvalid;
  logic      s_axi_lite_bready;
  reg_addr_t s_axi_lite_araddr;
  logic      s_axi_lite_arvalid;
  logic      s_axi_lite_arready;
  data_t     s_axi_lite_rdata;
  resp_t     s_axi_lite_rresp;
  logic      s_axi_lite_rvalid;
  logic      s_axi_lite_rready;
  data_t     s_axi_stream_tdata;
  logic      s_axi_stream_tvalid;
  logic      s_axi_stream_tready;
  logic      s_axi_stream_tlast;

  data_t       model_mem [DEPTH];  // Expected RAM contents
  int          model_count = 0;    // Expected word_count
  logic [31:0] lfsr;
  int          cycle  = 0;
  int          errors = 0;
  int          checks = 0;

  `include "capture_tasks.svh"

  axi_capture_top #(.MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)) dut0 (.*);

  initial begin
    aclk = 1'b0;
    forever #5 aclk = ~aclk;  // 100 MHz
  end

  // Cycle count and watchdog
  always @(posedge aclk) begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles, DUT is hung", cycle);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    data_t d;
    strb_t s;
    resp_t r;
    int    idx;
    lfsr                = 32'h1883_12d6;
    reset               = 1'b1;
    s_axi_lite_awaddr   = '0;
    s_axi_lite_awvalid  = 1'b0;
    s_axi_lite_wdata    = '0;
    s_axi_lite_wstrb    = '0;
    s_axi_lite_wvalid   = 1'b0;
    s_axi_lite_bready   = 1'b0;
    s_axi_lite_araddr   = '0;
    s_axi_lite_arvalid  = 1'b0;
    s_axi_lite_rready   = 1'b0;
    s_axi_stream_tdata  = '0;
    s_axi_stream_tvalid = 1'b0;
    s_axi_stream_tlast  = 1'b0;
    repeat (3) @(posedge aclk);
    #1;
    reset = 1'b0;

    // Register values out of reset
    read_check(REG_STATUS, 32'h0, "STATUS after reset");
    read_check(REG_CTRL, 32'h0, "CTRL after reset");
    read_check(REG_ID, ID_WORD, "ID register");

    // Fill every word, then strobed overwrites, then read back
    for (int i = 0; i < DEPTH; i++) begin
      d = take_bits(32);
      write_check(window_addr(i), d, 4'hf);
    end
    repeat (40) begin
      idx = take_bits(MEM_ADDR_WIDTH);
      d   = take_bits(32);
      s   = take_bits(4);
      write_check(window_addr(idx), d, s);
    end
    for (int i = 0; i < DEPTH; i++) begin
      read_check(window_addr(i), model_mem[i], $sformatf("window word %0d", i));
    end

    // One 20 word frame
    write_check(REG_CTRL, 32'h1, 4'h1);
    for (int i = 0; i < 20; i++) begin
      d = take_bits(32);
      send_beat(d, i == 19, 1'b1);
    end
    read_check(REG_STATUS, 32'h4000_0014, "STATUS after frame");  // frame_done, count 20
    for (int i = 0; i < 20; i++) begin
      read_check(window_addr(i), model_mem[i], $sformatf("captured word %0d", i));
    end

    // Window reads racing a 30 word frame
    write_check(REG_CTRL, 32'h3, 4'h1);  // Clear, keep capture on
    model_count = 0;
    fork
      begin
        data_t sd;
        for (int i = 0; i < 30; i++) begin
          sd = take_bits(32);
          send_beat(sd, i == 29, 1'b1);
        end
      end
      begin
        int ri;
        repeat (15) begin
          wait (model_count > 0);
          ri = take_bits(8) % model_count;  // Only words already counted
          read_check(window_addr(ri), model_mem[ri], $sformatf("live read word %0d", ri));
        end
      end
    join
    read_check(REG_STATUS, 32'h4000_001e, "STATUS after shared frame");
    for (int i = 0; i < 30; i++) begin
      read_check(window_addr(i), model_mem[i], $sformatf("shared word %0d", i));
    end

    // Overflow, the last 6 beats must stall
    write_check(REG_CTRL, 32'h3, 4'h1);
    model_count = 0;
    for (int i = 0; i < 70; i++) begin
      d = take_bits(32);
      send_beat(d, i == DEPTH - 1, i < DEPTH);  // tlast on the beat that fills it
    end
    read_check(REG_STATUS, 32'hc000_0040, "STATUS when full");  // Both flags, count 64
    read_check(window_addr(DEPTH - 1), model_mem[DEPTH - 1], "last word holds beat 64");
    write_check(REG_CTRL, 32'h2, 4'h1);  // Clear with capture off
    model_count = 0;
    read_check(REG_STATUS, 32'h0, "STATUS after clear");
    read_check(REG_CTRL, 32'h0, "CTRL after clear");

    // Unmapped address
    lite_read(12'h100, d, r);
    check_value(r, SLVERR_CODE, "read response at 0x100");
    check_value(d, 32'h0, "read data at 0x100");
    d = take_bits(32) | 32'h1;  // Enable bit set, a stray CTRL write would show
    lite_write(12'h100, d, 4'hf, r);
    check_value(r, SLVERR_CODE, "write response at 0x100");
    read_check(REG_CTRL, 32'h0, "CTRL after bad write");
    read_check(REG_STATUS, 32'h0, "STATUS after bad write");

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- files.f
+incdir+verification
rtl/capture_pkg.sv
rtl/shared_ram.sv
rtl/mem_arbiter.sv
rtl/stream_sink.sv
rtl/ctrl_regs.sv
rtl/axi_lite_slave.sv
rtl/axi_capture_top.sv
verification/capture_tb.sv
